//--- verilog/awg_cfg_pkg.sv
package awg_cfg_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	typedef logic [7:0]  byte_t;       // One byte from the UART receiver
	typedef logic [63:0] cmd_word_t;   // Eight payload bytes, first byte in 7:0
	typedef logic [23:0] param_t;      // Delay, length or start address value
	typedef logic [3:0]  slot_t;       // Card slot number
	typedef logic [4:0]  ga_t;         // Backplane geographic address
	typedef logic [1:0]  chan_t;       // Channel select
	typedef logic [3:0]  seg_t;        // Segment select

	// Parameter kind, command bits 31:28
	typedef enum logic [3:0]
	{
		KIND_DELAY = 4'd0,             // Output delay
		KIND_LEN   = 4'd1,             // Segment length
		KIND_ADDR  = 4'd2              // Segment start address
	} kind_t;

	// Frame parser states
	typedef enum logic [2:0]
	{
		HEAD1   = 3'd0,                // Waiting for first header byte
		HEAD2   = 3'd1,                // Waiting for second header byte
		PAYLOAD = 3'd2,                // Collecting payload
		DONE    = 3'd3,                // Frame complete, one cycle
		ERROR   = 3'd4                 // Bad header, one cycle
	} parser_state_t;

	//////////////////////////////
	// Frame format
	//////////////////////////////

	localparam byte_t HEAD_BYTE1    = 8'hEB;  // Sync byte 1
	localparam byte_t HEAD_BYTE2    = 8'h9C;  // Sync byte 2
	localparam int    PAYLOAD_BYTES = 8;      // Bytes per command word
	localparam int    NUM_CH        = 4;      // Set by the 2-bit channel field

	//////////////////////////////
	// Reset defaults
	//////////////////////////////

	localparam param_t DEFAULT_LEN = 24'd250; // Length of every segment
	localparam param_t ADDR_STEP   = 24'd250; // Segments packed back to back

endpackage

//--- verilog/param_wr_if.sv
interface param_wr_if #(
	parameter int NUM_SEG = 3              // Segments per channel
);

	logic                   wr_en;         // Write strobe, one cycle
	awg_cfg_pkg::chan_t     wr_chan;       // Target channel
	awg_cfg_pkg::kind_t     wr_kind;       // Target register array
	awg_cfg_pkg::seg_t      wr_seg;        // Target segment
	awg_cfg_pkg::param_t    wr_data;       // New register value
	logic                   seg_ok;        // Segment inside the bank

	assign seg_ok = (wr_seg < NUM_SEG);    // Range check for the sink side

	modport source (output wr_en, output wr_chan, output wr_kind, output wr_seg,
		output wr_data);
	modport sink (input wr_en, input wr_chan, input wr_kind, input wr_seg,
		input wr_data, input seg_ok);

endinterface

//--- verilog/frame_parser.sv
module frame_parser (
	input  logic                   clk,
	input  logic                   rst_n,
	input  awg_cfg_pkg::byte_t     frame_byte,     // Byte from UART receiver
	input  logic                   frame_byte_en,  // Byte strobe
	output awg_cfg_pkg::cmd_word_t cmd_word,       // Assembled payload
	output logic                   cmd_valid       // Frame complete pulse
);

	localparam int CNT_W = $clog2(awg_cfg_pkg::PAYLOAD_BYTES);
	localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(awg_cfg_pkg::PAYLOAD_BYTES - 1);

	awg_cfg_pkg::parser_state_t state;       // Current state
	awg_cfg_pkg::parser_state_t state_nxt;   // Next state
	logic [CNT_W-1:0]           byte_cnt;    // Payload byte index

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= awg_cfg_pkg::HEAD1;     // Start in header search
		else
			state <= state_nxt;
	end

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		state_nxt = state;                   // Hold by default
		case (state)
			awg_cfg_pkg::HEAD1:
			begin
				if (frame_byte_en)
				begin
					if (frame_byte == awg_cfg_pkg::HEAD_BYTE1)
						state_nxt = awg_cfg_pkg::HEAD2;
					else
						state_nxt = awg_cfg_pkg::ERROR;   // Not a sync byte
				end
			end
			awg_cfg_pkg::HEAD2:
			begin
				if (frame_byte_en)
				begin
					if (frame_byte == awg_cfg_pkg::HEAD_BYTE2)
						state_nxt = awg_cfg_pkg::PAYLOAD;
					else
						state_nxt = awg_cfg_pkg::ERROR;   // Broken header
				end
			end
			awg_cfg_pkg::PAYLOAD:
			begin
				if (frame_byte_en && (byte_cnt == LAST_BYTE))
					state_nxt = awg_cfg_pkg::DONE;        // Eighth byte taken
			end
			awg_cfg_pkg::DONE:  state_nxt = awg_cfg_pkg::HEAD1;  // Strobe ignored here
			awg_cfg_pkg::ERROR: state_nxt = awg_cfg_pkg::HEAD1;  // Back to search
			default:            state_nxt = awg_cfg_pkg::HEAD1;
		endcase
	end

	//////////////////////////////
	// Byte counter
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			byte_cnt <= '0;
		else if (state == awg_cfg_pkg::HEAD2)
			byte_cnt <= '0;                              // Fresh frame
		else if ((state == awg_cfg_pkg::PAYLOAD) && frame_byte_en)
			byte_cnt <= byte_cnt + 1'b1;                 // Next byte lane
	end

	// Payload assembly, each byte eight bits above the last
	always_ff @(posedge clk)
	begin
		if ((state == awg_cfg_pkg::PAYLOAD) && frame_byte_en)
			cmd_word[{byte_cnt, 3'b000} +: 8] <= frame_byte;
	end

	// One cycle per good frame, a clock after DONE is entered
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= (state == awg_cfg_pkg::DONE);
	end

	// Back-to-back frames still give separate pulses
	a_valid_single : assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |=> !cmd_valid);

endmodule

//--- verilog/slot_cmd_decode.sv
module slot_cmd_decode #(
	parameter int NUM_SEG = 3                      // Segments per channel
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  awg_cfg_pkg::ga_t       ga,             // Geographic address
	input  awg_cfg_pkg::cmd_word_t cmd_word,       // Payload from parser
	input  logic                   cmd_valid,      // Payload valid pulse
	param_wr_if.source             wr              // Register write port
);

	awg_cfg_pkg::slot_t slot;      // This card's slot number
	logic               slot_hit;  // Command addressed to us
	logic               kind_ok;   // Delay, length or address
	logic               seg_ok;    // Segment exists in the bank

	//////////////////////////////
	// Slot lookup
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			slot <= '0;
		else
		begin
			case (ga) inside
				[5'd2:5'd8]:   slot <= awg_cfg_pkg::slot_t'(ga - 5'd1);  // Slots 1 to 7
				[5'd10:5'd17]: slot <= awg_cfg_pkg::slot_t'(ga - 5'd2);  // Slots 8 to 15
				default:       slot <= '0;       // 0, 1, 9 and unused addresses
			endcase
		end
	end

	//////////////////////////////
	// Command checks
	//////////////////////////////

	assign slot_hit = (cmd_word[39:36] == slot);
	assign kind_ok  = cmd_word[31:28] inside {awg_cfg_pkg::KIND_DELAY,
		awg_cfg_pkg::KIND_LEN, awg_cfg_pkg::KIND_ADDR};
	assign seg_ok   = (cmd_word[27:24] < NUM_SEG);

	// Register write, same cycle as cmd_valid
	assign wr.wr_en   = cmd_valid && slot_hit && kind_ok && seg_ok;
	assign wr.wr_chan = cmd_word[35:34];                            // Channel field
	assign wr.wr_kind = awg_cfg_pkg::kind_t'(cmd_word[31:28]);      // Kind field
	assign wr.wr_seg  = cmd_word[27:24];                            // Segment field
	assign wr.wr_data = cmd_word[23:0];                             // Value field

endmodule

//--- verilog/awg_param_regs.sv
module awg_param_regs #(
	parameter int NUM_SEG = 3                          // Segments per channel
) (
	input  logic                clk,
	input  logic                rst_n,
	param_wr_if.sink            wr,                    // Write port from decoder
	output awg_cfg_pkg::param_t ch_delay [awg_cfg_pkg::NUM_CH*NUM_SEG], // Per segment, channel
	output awg_cfg_pkg::param_t ch_len   [awg_cfg_pkg::NUM_CH*NUM_SEG],
	output awg_cfg_pkg::param_t ch_addr  [awg_cfg_pkg::NUM_CH*NUM_SEG]
);

	//////////////////////////////
	// Register bank
	//////////////////////////////

	for (genvar s = 0; s < NUM_SEG; s++)
	begin : g_seg
		for (genvar c = 0; c < awg_cfg_pkg::NUM_CH; c++)
		begin : g_ch
			localparam int E = s * awg_cfg_pkg::NUM_CH + c;   // Element index
			logic hit;                                       // This element addressed

			assign hit = wr.wr_en
				&& (wr.wr_seg == awg_cfg_pkg::seg_t'(s))
				&& (wr.wr_chan == awg_cfg_pkg::chan_t'(c));

			always_ff @(posedge clk or negedge rst_n)
			begin
				if (!rst_n)
				begin
					ch_delay[E] <= '0;                              // No delay
					ch_len[E]   <= awg_cfg_pkg::DEFAULT_LEN;        // Default length
					ch_addr[E]  <= awg_cfg_pkg::param_t'(awg_cfg_pkg::ADDR_STEP * s);
				end
				else if (hit)
				begin
					case (wr.wr_kind)
						awg_cfg_pkg::KIND_DELAY: ch_delay[E] <= wr.wr_data;
						awg_cfg_pkg::KIND_LEN:   ch_len[E]   <= wr.wr_data;
						awg_cfg_pkg::KIND_ADDR:  ch_addr[E]  <= wr.wr_data;
						default: ;                                    // Filtered upstream
					endcase
				end
			end
		end
	end

	// Decoder only lets through writes that land in this bank
	a_wr_legal : assert property (@(posedge clk) disable iff (!rst_n)
		wr.wr_en |-> (wr.seg_ok && (wr.wr_kind inside {awg_cfg_pkg::KIND_DELAY,
			awg_cfg_pkg::KIND_LEN, awg_cfg_pkg::KIND_ADDR})));

endmodule

//--- verilog/awg_cfg_top.sv
module awg_cfg_top #(
	parameter int NUM_SEG = 3                          // Segments per channel, 1 to 16
) (
	input  logic                clk,
	input  logic                rst_n,
	input  awg_cfg_pkg::byte_t  frame_byte,            // UART byte
	input  logic                frame_byte_en,         // UART byte strobe
	input  awg_cfg_pkg::ga_t    ga,                    // Backplane address
	output awg_cfg_pkg::param_t ch_delay [awg_cfg_pkg::NUM_CH*NUM_SEG], // Delay per channel
	output awg_cfg_pkg::param_t ch_len   [awg_cfg_pkg::NUM_CH*NUM_SEG], // Segment lengths
	output awg_cfg_pkg::param_t ch_addr  [awg_cfg_pkg::NUM_CH*NUM_SEG]  // Segment start
);

	awg_cfg_pkg::cmd_word_t cmd_word;                  // Parser to decoder
	logic                   cmd_valid;                 // Frame complete

	param_wr_if #(.NUM_SEG(NUM_SEG)) u_wr_if ();       // Decoder to register bank

	//////////////////////////////
	// Receive chain
	//////////////////////////////

	frame_parser u_frame_parser (
		.clk           (clk),
		.rst_n         (rst_n),
		.frame_byte    (frame_byte),
		.frame_byte_en (frame_byte_en),
		.cmd_word      (cmd_word),
		.cmd_valid     (cmd_valid)
	);

	slot_cmd_decode #(.NUM_SEG(NUM_SEG)) u_slot_cmd_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.ga        (ga),
		.cmd_word  (cmd_word),
		.cmd_valid (cmd_valid),
		.wr        (u_wr_if.source)
	);

	awg_param_regs #(.NUM_SEG(NUM_SEG)) u_awg_param_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (u_wr_if.sink),
		.ch_delay (ch_delay),
		.ch_len   (ch_len),
		.ch_addr  (ch_addr)
	);

endmodule

//--- verification/include/awg_cfg_model.svh
`ifndef AWG_CFG_MODEL_SVH
`define AWG_CFG_MODEL_SVH

//////////////////////////////
// Expected register bank
//////////////////////////////

logic [23:0] exp_delay [NUM_EL];   // Index is segment * 4 + channel
logic [23:0] exp_len   [NUM_EL];
logic [23:0] exp_addr  [NUM_EL];

// Backplane address to slot number
function automatic logic [3:0] slot_of_ga(input logic [4:0] addr);
	if ((addr >= 5'd2) && (addr <= 5'd8))
		return 4'(addr - 5'd1);        // Slots 1 to 7
	else if ((addr >= 5'd10) && (addr <= 5'd17))
		return 4'(addr - 5'd2);        // Slots 8 to 15
	else
		return 4'd0;                   // 0, 1, 9 and the rest
endfunction

task automatic model_reset();
	for (int s = 0; s < NUM_SEG; s++)
	begin
		for (int c = 0; c < 4; c++)
		begin
			exp_delay[s * 4 + c] = 24'd0;
			exp_len[s * 4 + c]   = 24'd250;
			exp_addr[s * 4 + c]  = 24'(250 * s);   // Segments back to back
		end
	end
endtask

// Slot, kind and segment all have to be legal
function automatic bit cmd_accepted(input logic [63:0] w, input logic [4:0] addr);
	logic slot_ok;
	logic kind_ok;
	logic seg_ok;
	slot_ok = (w[39:36] == slot_of_ga(addr));
	kind_ok = (w[31:28] <= 4'd2);      // Delay, length, address
	seg_ok  = (int'(w[27:24]) < NUM_SEG);
	return slot_ok && kind_ok && seg_ok;
endfunction

task automatic model_write(input logic [63:0] w, input logic [4:0] addr);
	int idx;
	if (cmd_accepted(w, addr))
	begin
		idx = int'(w[27:24]) * 4 + int'(w[35:34]);
		case (w[31:28])
			4'd0:    exp_delay[idx] = w[23:0];
			4'd1:    exp_len[idx]   = w[23:0];
			default: exp_addr[idx]  = w[23:0];
		endcase
	end
endtask

`endif

//--- verification/tb_awg_cfg.sv
module tb_awg_cfg;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_SEG      = 3;
	localparam int NUM_EL       = 4 * NUM_SEG;              // Channels times segments
	localparam int FRAME_CYCLES = 50;                       // 10 bytes of up to 4 cycles, plus wait
	localparam int NUM_FRAMES   = 200;                      // Upper bound over all tests
	localparam int MAX_CYCLES   = 2 * FRAME_CYCLES * NUM_FRAMES;

	logic                clk;
	logic                rst_n;
	logic [7:0]          frame_byte;
	logic                frame_byte_en;
	logic [4:0]          ga;
	awg_cfg_pkg::param_t ch_delay [NUM_EL];
	awg_cfg_pkg::param_t ch_len   [NUM_EL];
	awg_cfg_pkg::param_t ch_addr  [NUM_EL];

	`include "awg_cfg_model.svh"

	integer      seed = 94;                                 // Random stream seed
	int          err_cnt = 0;                               // Mismatches so far
	int          check_cnt = 0;
	int          clean_tests = 0;
	int          err_mark;
	int          cycle_cnt = 0;
	int          sel;
	logic [63:0] w;
	logic [7:0]  bad;
	logic [3:0]  slot;
	logic [4:0]  ga_list [6] = '{5'd0, 5'd9, 5'd17, 5'd20, 5'd3, 5'd14};

	awg_cfg_top #(.NUM_SEG(NUM_SEG)) u_awg_cfg_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.frame_byte    (frame_byte),
		.frame_byte_en (frame_byte_en),
		.ga            (ga),
		.ch_delay      (ch_delay),
		.ch_len        (ch_len),
		.ch_addr       (ch_addr)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;                             // 20 ns period
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic int pick_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [63:0] make_cmd(input logic [3:0] slot_v, input logic [1:0] chan,
		input logic [3:0] kind, input logic [3:0] seg, input logic [23:0] value);
		logic [63:0] c;
		c = {$random(seed), $random(seed)};                 // Junk in unused fields
		c[39:36] = slot_v;
		c[35:34] = chan;
		c[31:28] = kind;
		c[27:24] = seg;
		c[23:0]  = value;
		return c;
	endfunction

	// Keeps a discarded frame from looking like a new header
	function automatic logic [63:0] strip_sync_bytes(input logic [63:0] c);
		for (int i = 0; i < 8; i++)
			if (c[8*i +: 8] == 8'hEB)
				c[8*i +: 8] = 8'h00;
		return c;
	endfunction

	// Called and returns at 2 ns after a rising edge
	task automatic drive_byte(input logic [7:0] b);
		int gap;
		gap = 1 + pick_below(3);                            // 1 to 3 idle cycles
		frame_byte    = b;
		frame_byte_en = 1'b1;
		@(posedge clk);
		#2;
		frame_byte_en = 1'b0;
		repeat (gap)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_frame(input logic [7:0] h1, input logic [7:0] h2, input logic [63:0] c);
		drive_byte(h1);
		drive_byte(h2);
		for (int i = 0; i < 8; i++)
			drive_byte(c[8*i +: 8]);                        // Low byte first
		repeat (4)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	//////////////////////////////
	// Checking
	//////////////////////////////

	task automatic compare_value(input string name, input int idx, input logic [23:0] exp_v,
		input logic [23:0] act_v);
		check_cnt++;
		assert (act_v === exp_v)
		else
		begin
			$display("Fail at %0t ns: %s[%0d] expected %0d, actual %0d", $time, name, idx,
				exp_v, act_v);
			err_cnt++;
		end
	endtask

	task automatic check_outputs();
		for (int e = 0; e < NUM_EL; e++)
		begin
			compare_value("ch_delay", e, exp_delay[e], ch_delay[e]);
			compare_value("ch_len", e, exp_len[e], ch_len[e]);
			compare_value("ch_addr", e, exp_addr[e], ch_addr[e]);
		end
	endtask

	task automatic report_test(input int num, input string name, input int mark);
		if (err_cnt == mark)
			clean_tests++;
		$display("Test %0d, %s: %0d mismatches", num, name, err_cnt - mark);
	endtask

	// Valid frame to the given slot, then model update and full compare
	task automatic run_valid(input logic [3:0] slot_v);
		w = make_cmd(slot_v, 2'(pick_below(4)), 4'(pick_below(3)), 4'(pick_below(NUM_SEG)),
			24'($random(seed)));
		send_frame(8'hEB, 8'h9C, w);
		model_write(w, ga);
		check_outputs();
	endtask

	// Watchdog
	initial
	begin
		while (cycle_cnt < MAX_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: run still busy after %0d clock cycles", MAX_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		frame_byte    = 8'h00;
		frame_byte_en = 1'b0;
		ga            = 5'd5;                               // Slot 4
		rst_n         = 1'b0;
		model_reset();
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		#2;

		err_mark = err_cnt;
		check_outputs();
		report_test(1, "reset defaults", err_mark);

		err_mark = err_cnt;
		repeat (60)
			run_valid(slot_of_ga(ga));
		report_test(2, "valid frames", err_mark);

		err_mark = err_cnt;
		repeat (45)
		begin
			slot = slot_of_ga(ga);
			w = make_cmd(slot, 2'(pick_below(4)), 4'(pick_below(3)), 4'(pick_below(NUM_SEG)),
				24'($random(seed)));
			sel = pick_below(3);
			case (sel)
				0:       w[39:36] = slot ^ 4'(1 + pick_below(15));       // Other slot
				1:       w[31:28] = 4'(3 + pick_below(13));              // Kind 3 to 15
				default: w[27:24] = 4'(NUM_SEG + pick_below(16 - NUM_SEG));
			endcase
			send_frame(8'hEB, 8'h9C, w);
			model_write(w, ga);
			check_outputs();
		end
		report_test(3, "ignored commands", err_mark);

		err_mark = err_cnt;
		for (int k = 0; k < 20; k++)
		begin
			w   = strip_sync_bytes(make_cmd(slot_of_ga(ga), 2'(pick_below(4)), 4'd0, 4'd0,
				24'($random(seed))));
			bad = 8'($random(seed));
			if (k % 2 == 0)
			begin
				if (bad == 8'hEB)
					bad = 8'hEA;
				send_frame(bad, 8'h9C, w);                  // Broken first header byte
			end
			else
			begin
				if (bad == 8'h9C)
					bad = 8'h9D;
				send_frame(8'hEB, bad, w);                  // Broken second header byte
			end
			check_outputs();
			run_valid(slot_of_ga(ga));                      // Parser must resync
		end
		report_test(4, "corrupted headers", err_mark);

		err_mark = err_cnt;
		for (int i = 0; i < 6; i++)
		begin
			ga = ga_list[i];
			repeat (2)
			begin
				@(posedge clk);
				#2;
			end
			repeat (2)
				run_valid(slot_of_ga(ga));
			repeat (2)
				run_valid(slot_of_ga(ga) ^ 4'(1 + pick_below(15)));   // Must be dropped
		end
		report_test(5, "geographic address", err_mark);

		$display("Summary: %0d of 5 tests clean, %0d checks, %0d mismatches", clean_tests,
			check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verification/include
verilog/awg_cfg_pkg.sv
verilog/param_wr_if.sv
verilog/frame_parser.sv
verilog/slot_cmd_decode.sv
verilog/awg_param_regs.sv
verilog/awg_cfg_top.sv
verification/tb_awg_cfg.sv

//--- run.sh
#!/bin/sh
# Build and run the AWG configuration receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_awg_cfg
./obj_dir/Vtb_awg_cfg | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
else
	exit 1
fi
